// File: verilog/dot_settings.svh
`ifndef DOT_SETTINGS_SVH
`define DOT_SETTINGS_SVH

// number of element pairs per dot product
`define DOT_VLEN 4

// single precision field widths, mantissa width without the hidden one
`define FP_EXP_W 8
`define FP_MAN_W 23

// exponent bias and the all-ones exponent used for infinity
`define FP_BIAS 127
`define FP_EXP_MAX 255

`endif

// File: verilog/fp_pkg.sv
`default_nettype none

package fp_pkg;

    `include "dot_settings.svh"

    // one ieee-754 single precision word
    typedef logic [`FP_EXP_W+`FP_MAN_W:0] fp32_t;

    // biased exponent field
    typedef logic [`FP_EXP_W-1:0] fp_exp_t;

    // stored fraction, hidden one not included
    typedef logic [`FP_MAN_W-1:0] fp_frac_t;

    // mantissa with the hidden one in the top bit
    typedef logic [`FP_MAN_W:0] fp_man_t;

    // signed exponent with two guard bits for overflow and underflow checks
    typedef logic signed [`FP_EXP_W+1:0] fp_exp_ext_t;

    // field view of a word, same bit layout as fp32_t
    typedef struct packed {
        logic     sign;
        fp_exp_t  exp;
        fp_frac_t frac;
    } fp_fields_t;

endpackage

`default_nettype wire

// File: verilog/dot_pkg.sv
`default_nettype none

package dot_pkg;

    `include "dot_settings.svh"

    // whole input vector, element 0 in the lowest word
    typedef logic [`DOT_VLEN*$bits(fp_pkg::fp32_t)-1:0] vec_t;

    // element index, one extra code so it can count up to DOT_VLEN
    typedef logic [$clog2(`DOT_VLEN+1)-1:0] idx_t;

    // fetch stage output, one element pair
    typedef struct packed {
        logic          valid;
        logic          last;
        fp_pkg::fp32_t a;
        fp_pkg::fp32_t b;
    } pair_t;

    // multiply stage output, one product
    typedef struct packed {
        logic          valid;
        logic          last;
        fp_pkg::fp32_t value;
    } product_t;

    // fetch fsm
    typedef enum logic {
        FETCH_IDLE,
        FETCH_ISSUE
    } fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/dot_fetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_settings.svh"

module dot_fetch (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire dot_pkg::vec_t   a_vec,
    input  wire dot_pkg::vec_t   b_vec,
    output dot_pkg::pair_t       pair,
    output logic                 restart
);

    localparam int WORD_W = $bits(fp_pkg::fp32_t);

    // copy of the vectors the current computation works on
    dot_pkg::vec_t a_hold;
    dot_pkg::vec_t b_hold;

    // forces one computation of the reset-time inputs
    logic pending;
    logic changed;

    dot_pkg::fetch_state_t state;
    dot_pkg::idx_t         idx;

    logic          pair_valid;
    logic          pair_last;
    fp_pkg::fp32_t pair_a;
    fp_pkg::fp32_t pair_b;

    // compare against the stored copy every cycle
    assign changed = pending || (a_vec != a_hold) || (b_vec != b_hold);

    // sampled copy, only loaded on a change
    always_ff @(posedge clk) begin
        if (changed) begin
            a_hold <= a_vec;
            b_hold <= b_vec;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending    <= 1'b1;
            restart    <= 1'b0;
            state      <= dot_pkg::FETCH_IDLE;
            idx        <= '0;
            pair_valid <= 1'b0;
            pair_last  <= 1'b0;
        end else if (changed) begin
            // new inputs, drop whatever was being issued and start over
            pending    <= 1'b0;
            restart    <= 1'b1;
            state      <= dot_pkg::FETCH_ISSUE;
            idx        <= '0;
            pair_valid <= 1'b0;
            pair_last  <= 1'b0;
        end else begin
            restart <= 1'b0;
            case (state)
                dot_pkg::FETCH_ISSUE: begin
                    pair_valid <= 1'b1;
                    pair_last  <= (idx == dot_pkg::idx_t'(`DOT_VLEN - 1));
                    idx        <= idx + dot_pkg::idx_t'(1);
                    // last element goes out on this edge
                    if (idx == dot_pkg::idx_t'(`DOT_VLEN - 1)) begin
                        state <= dot_pkg::FETCH_IDLE;
                    end
                end
                default: begin
                    pair_valid <= 1'b0;
                    pair_last  <= 1'b0;
                end
            endcase
        end
    end

    // element slices come from the held copy, inputs may move meanwhile
    always_ff @(posedge clk) begin
        pair_a <= a_hold[int'(idx)*WORD_W +: WORD_W];
        pair_b <= b_hold[int'(idx)*WORD_W +: WORD_W];
    end

    assign pair = '{valid: pair_valid, last: pair_last, a: pair_a, b: pair_b};

    // index stays inside the vector for the whole issue phase
    idx_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        (state == dot_pkg::FETCH_ISSUE) |-> (idx < dot_pkg::idx_t'(`DOT_VLEN)));

endmodule

`default_nettype wire

// File: verilog/fp_mul_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_settings.svh"

module fp_mul_stage (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   restart,
    input  wire dot_pkg::pair_t   pair,
    output dot_pkg::product_t     prod
);

    fp_pkg::fp_fields_t fa;
    fp_pkg::fp_fields_t fb;
    fp_pkg::fp_man_t    ma;
    fp_pkg::fp_man_t    mb;

    // full 48 bit mantissa product
    logic [2*`FP_MAN_W+1:0] mprod;
    fp_pkg::fp_exp_ext_t    exp_res;
    fp_pkg::fp_frac_t       frac_res;
    logic                   sign_res;
    fp_pkg::fp32_t          value_next;

    logic          prod_valid;
    logic          prod_last;
    fp_pkg::fp32_t prod_value;

    assign fa = pair.a;
    assign fb = pair.b;

    always_comb begin
        sign_res = fa.sign ^ fb.sign;
        ma       = {1'b1, fa.frac};
        mb       = {1'b1, fb.frac};
        mprod    = {{(`FP_MAN_W+1){1'b0}}, ma} * {{(`FP_MAN_W+1){1'b0}}, mb};
        exp_res  = $signed({2'b00, fa.exp}) + $signed({2'b00, fb.exp})
                   - fp_pkg::fp_exp_ext_t'(`FP_BIAS);
        // product of two 1.x values lies in [1,4), at most one shift
        if (mprod[2*`FP_MAN_W+1]) begin
            frac_res = mprod[2*`FP_MAN_W -: `FP_MAN_W];
            exp_res  = exp_res + fp_pkg::fp_exp_ext_t'(1);
        end else begin
            frac_res = mprod[2*`FP_MAN_W-1 -: `FP_MAN_W];
        end
        // low bits are dropped, truncation toward zero
        if (fa.exp == '0 || fb.exp == '0) begin
            // zero or denormal operand
            value_next = '0;
        end else if (exp_res >= fp_pkg::fp_exp_ext_t'(`FP_EXP_MAX)) begin
            value_next = {sign_res, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
        end else if (exp_res <= fp_pkg::fp_exp_ext_t'(0)) begin
            value_next = '0;
        end else begin
            value_next = {sign_res, exp_res[`FP_EXP_W-1:0], frac_res};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            // restart kills the item registered on this edge
            prod_valid <= pair.valid && !restart;
            prod_last  <= pair.last && !restart;
        end
    end

    always_ff @(posedge clk) begin
        prod_value <= value_next;
    end

    assign prod = '{valid: prod_valid, last: prod_last, value: prod_value};

    // stale products never leave this stage after a restart
    no_prod_after_restart: assert property (@(posedge clk) disable iff (!arst_n)
        restart |=> !prod.valid);

endmodule

`default_nettype wire

// File: verilog/fp_add.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_settings.svh"

module fp_add (
    input  wire fp_pkg::fp32_t a,
    input  wire fp_pkg::fp32_t b,
    output fp_pkg::fp32_t      sum
);

    localparam int LZ_W = $clog2(`FP_MAN_W + 1);

    fp_pkg::fp_fields_t fa;
    fp_pkg::fp_fields_t fb;

    // operands ordered by magnitude
    fp_pkg::fp_fields_t big;
    fp_pkg::fp_fields_t little;

    fp_pkg::fp_man_t     m_big;
    fp_pkg::fp_man_t     m_shift;
    fp_pkg::fp_exp_t     exp_diff;

    // one carry bit above the hidden one
    logic [`FP_MAN_W+1:0] m_sum;
    logic [`FP_MAN_W+1:0] m_norm;
    logic [LZ_W-1:0]      lz;
    logic                 lz_found;
    fp_pkg::fp_exp_ext_t  exp_res;

    assign fa = a;
    assign fb = b;

    always_comb begin
        // compare exponent and fraction together as one magnitude
        if ({fa.exp, fa.frac} >= {fb.exp, fb.frac}) begin
            big    = fa;
            little = fb;
        end else begin
            big    = fb;
            little = fa;
        end
        m_big    = {1'b1, big.frac};
        exp_diff = big.exp - little.exp;
        // bits shifted out are lost
        m_shift  = {1'b1, little.frac} >> exp_diff;

        if (big.sign == little.sign) begin
            m_sum = {1'b0, m_big} + {1'b0, m_shift};
        end else begin
            // never negative since big has the larger magnitude
            m_sum = {1'b0, m_big} - {1'b0, m_shift};
        end

        // leading zeros below the carry bit
        lz       = '0;
        lz_found = 1'b0;
        for (int i = `FP_MAN_W; i >= 0; i--) begin
            if (!lz_found && m_sum[i]) begin
                lz       = LZ_W'(`FP_MAN_W - i);
                lz_found = 1'b1;
            end
        end

        if (m_sum[`FP_MAN_W+1]) begin
            // carry out, shift right once
            m_norm  = m_sum >> 1;
            exp_res = $signed({2'b00, big.exp}) + fp_pkg::fp_exp_ext_t'(1);
        end else begin
            m_norm  = m_sum << lz;
            exp_res = $signed({2'b00, big.exp}) - $signed({{(`FP_EXP_W+2-LZ_W){1'b0}}, lz});
        end

        if (fa.exp == '0) begin
            // zero operand, the other passes untouched
            sum = b;
        end else if (fb.exp == '0) begin
            sum = a;
        end else if (m_sum == '0) begin
            // exact cancellation is always +0
            sum = '0;
        end else if (exp_res >= fp_pkg::fp_exp_ext_t'(`FP_EXP_MAX)) begin
            sum = {big.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
        end else if (exp_res <= fp_pkg::fp_exp_ext_t'(0)) begin
            sum = '0;
        end else begin
            sum = {big.sign, exp_res[`FP_EXP_W-1:0], m_norm[`FP_MAN_W-1:0]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/dot_acc_stage.sv
`timescale 1ns/10ps
`default_nettype none

module dot_acc_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      restart,
    input  wire dot_pkg::product_t   prod,
    output fp_pkg::fp32_t            result,
    output logic                     done
);

    // running sum plus the incoming product
    fp_pkg::fp32_t sum_next;

    fp_add fp_add_inst (
        .a   (result),
        .b   (prod.value),
        .sum (sum_next)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else if (restart) begin
            // start from +0, the product arriving now is stale
            result <= '0;
            done   <= 1'b0;
        end else if (prod.valid) begin
            result <= sum_next;
            // last element added, result holds until the next restart
            if (prod.last) begin
                done <= 1'b1;
            end
        end
    end

    // fetch issues nothing new after the last pair until a restart
    no_prod_when_done: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> !prod.valid);

endmodule

`default_nettype wire

// File: verilog/dot_product_seq.sv
`timescale 1ns/10ps
`default_nettype none

module dot_product_seq (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire dot_pkg::vec_t   a_vec,
    input  wire dot_pkg::vec_t   b_vec,
    output fp_pkg::fp32_t        result,
    output logic                 done
);

    // fetch to multiply
    dot_pkg::pair_t    pair;

    // one cycle pulse on every input change
    logic              restart;

    // multiply to accumulate
    dot_pkg::product_t prod;

    // stage 1, change detection and element stepping
    dot_fetch dot_fetch_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .a_vec   (a_vec),
        .b_vec   (b_vec),
        .pair    (pair),
        .restart (restart)
    );

    // stage 2, one float multiply per cycle
    fp_mul_stage fp_mul_stage_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .restart (restart),
        .pair    (pair),
        .prod    (prod)
    );

    // stage 3, accumulation and done
    dot_acc_stage dot_acc_stage_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .restart (restart),
        .prod    (prod),
        .result  (result),
        .done    (done)
    );

endmodule

`default_nettype wire

// File: testbench/dot_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_settings.svh"

module dot_checker (
    input  wire                clk,
    input  wire                arst_n,
    input  wire dot_pkg::vec_t a_vec,
    input  wire dot_pkg::vec_t b_vec,
    input  wire fp_pkg::fp32_t result,
    input  wire                done,
    output int                 errors,
    output int                 checks
);

    localparam int WORD_W = $bits(fp_pkg::fp32_t);
    // samples from the edge that takes new inputs to the sample that sees done
    localparam int DONE_LATENCY = `DOT_VLEN + 3;

    int            error_count = 0;
    int            check_count = 0;
    int            cyc = 0;
    int            change_cyc = 0;
    logic          armed = 1'b1;
    logic          done_q = 1'b0;
    dot_pkg::vec_t a_seen;
    dot_pkg::vec_t b_seen;
    fp_pkg::fp32_t expected;
    fp_pkg::fp32_t held;

    assign errors = error_count;
    assign checks = check_count;

    // product of two words, truncated, denormals flushed
    function automatic fp_pkg::fp32_t ref_mul(input fp_pkg::fp32_t x, input fp_pkg::fp32_t y);
        logic        sign;
        logic [47:0] p;
        logic [22:0] frac;
        int          e;

        sign = x[31] ^ y[31];
        if (x[30:23] == 8'd0 || y[30:23] == 8'd0) begin
            return '0;
        end
        p = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});
        e = int'(x[30:23]) + int'(y[30:23]) - 127;
        // 1.x times 1.x lies in [1,4)
        if (p[47]) begin
            frac = p[46:24];
            e    = e + 1;
        end else begin
            frac = p[45:23];
        end
        if (e >= 255) begin
            return {sign, 8'hff, 23'd0};
        end
        if (e <= 0) begin
            return '0;
        end
        return {sign, e[7:0], frac};
    endfunction

    // sum of two words, x is the running sum
    function automatic fp_pkg::fp32_t ref_add(input fp_pkg::fp32_t x, input fp_pkg::fp32_t y);
        fp_pkg::fp32_t hi;
        fp_pkg::fp32_t lo;
        logic [24:0]   m_hi;
        logic [24:0]   m_lo;
        logic [24:0]   m;
        int            shift;
        int            e;

        // a zero operand leaves the other one as it is
        if (x[30:23] == 8'd0) begin
            return y;
        end
        if (y[30:23] == 8'd0) begin
            return x;
        end
        // larger magnitude gives the sign, x wins a tie
        if (x[30:0] >= y[30:0]) begin
            hi = x;
            lo = y;
        end else begin
            hi = y;
            lo = x;
        end
        shift = int'(hi[30:23]) - int'(lo[30:23]);
        m_hi  = {2'b01, hi[22:0]};
        // smaller operand loses whatever is shifted out
        if (shift > 23) begin
            m_lo = '0;
        end else begin
            m_lo = {2'b01, lo[22:0]} >> shift;
        end
        if (hi[31] == lo[31]) begin
            m = m_hi + m_lo;
        end else begin
            m = m_hi - m_lo;
        end
        if (m == '0) begin
            return '0;
        end
        e = int'(hi[30:23]);
        // bring the leading one to bit 23
        while (m[24]) begin
            m = m >> 1;
            e = e + 1;
        end
        while (!m[23]) begin
            m = m << 1;
            e = e - 1;
        end
        if (e >= 255) begin
            return {hi[31], 8'hff, 23'd0};
        end
        if (e <= 0) begin
            return '0;
        end
        return {hi[31], e[7:0], m[22:0]};
    endfunction

    // element order accumulation from +0
    function automatic fp_pkg::fp32_t dot_ref(input dot_pkg::vec_t av, input dot_pkg::vec_t bv);
        fp_pkg::fp32_t acc;

        acc = '0;
        for (int i = 0; i < `DOT_VLEN; i++) begin
            acc = ref_add(acc, ref_mul(av[i*WORD_W +: WORD_W], bv[i*WORD_W +: WORD_W]));
        end
        return acc;
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            armed  = 1'b1;
            done_q = 1'b0;
        end else begin
            cyc = cyc + 1;
            // first edge out of reset, outputs still at their reset values
            if (armed && done !== 1'b0) begin
                $display("** Error at time %0t: done expected 0, actual %b", $time, done);
                error_count++;
            end
            if (armed && result !== '0) begin
                $display("** Error at time %0t: result expected 0x%08h, actual 0x%08h",
                         $time, 32'h0, result);
                error_count++;
            end
            if (done === 1'b1 && !done_q) begin
                check_count++;
                if (cyc - change_cyc != DONE_LATENCY) begin
                    $display(
                        "** Error at time %0t: done rose %0d cycles after the change, not %0d",
                        $time, cyc - change_cyc, DONE_LATENCY);
                    error_count++;
                end
                if (result !== expected) begin
                    $display("** Error at time %0t: result expected 0x%08h, actual 0x%08h",
                             $time, expected, result);
                    error_count++;
                end
                held = expected;
            end else if (done === 1'b1 && done_q) begin
                // inputs held, result frozen
                if (result !== held) begin
                    $display("** Error at time %0t: result expected 0x%08h, actual 0x%08h",
                             $time, held, result);
                    error_count++;
                end
            end else if (done !== 1'b1 && done_q) begin
                // only a restart clears done
                if (cyc - change_cyc > 2) begin
                    $display("** Error at time %0t: done fell with no input change before it",
                             $time);
                    error_count++;
                end
            end
            done_q = (done === 1'b1);
            // the DUT takes its inputs at this same edge
            if (armed || a_vec !== a_seen || b_vec !== b_seen) begin
                a_seen     = a_vec;
                b_seen     = b_vec;
                expected   = dot_ref(a_vec, b_vec);
                change_cyc = cyc;
                armed      = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_dot_product_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_settings.svh"

module tb_dot_product_seq;

    localparam int WORD_W = $bits(fp_pkg::fp32_t);
    // forty vector pairs at most, each well inside DOT_VLEN+10 cycles
    localparam int CYCLE_LIMIT = 40 * (`DOT_VLEN + 10);
    // done shows DOT_VLEN+3 cycles after apply and each pair is held DOT_VLEN+6 in all
    localparam int EXTRA_HOLD = 2;
    localparam int RANDOM_TESTS = 20;

    logic          clk;
    logic          arst_n;
    dot_pkg::vec_t a_vec;
    dot_pkg::vec_t b_vec;
    fp_pkg::fp32_t result;
    logic          done;

    logic [31:0] seed;
    int          cycles;
    int          done_expected;
    int          errors;
    int          checks;

    dot_product_seq dot_product_seq_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .a_vec  (a_vec),
        .b_vec  (b_vec),
        .result (result),
        .done   (done)
    );

    dot_checker dot_checker_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .a_vec  (a_vec),
        .b_vec  (b_vec),
        .result (result),
        .done   (done),
        .errors (errors),
        .checks (checks)
    );

    // 40 ns period
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(output logic [31:0] value);
        seed  = lcg_next(seed);
        value = seed;
    endtask

    function automatic dot_pkg::vec_t set_elem(input dot_pkg::vec_t v, input int i,
                                               input fp_pkg::fp32_t w);
        dot_pkg::vec_t r;

        r = v;
        r[i*WORD_W +: WORD_W] = w;
        return r;
    endfunction

    function automatic fp_pkg::fp32_t get_elem(input dot_pkg::vec_t v, input int i);
        return v[i*WORD_W +: WORD_W];
    endfunction

    // exponent 100..154 keeps products and sums in the normal range
    task automatic random_float(output fp_pkg::fp32_t f);
        logic [31:0] r1;
        logic [31:0] r2;
        int          e;

        draw(r1);
        draw(r2);
        e = 100 + int'(r1[31:16]) % 55;
        f = {r1[15], e[7:0], r2[31:9]};
    endtask

    task automatic random_vector(output dot_pkg::vec_t v);
        fp_pkg::fp32_t w;

        v = '0;
        for (int i = 0; i < `DOT_VLEN; i++) begin
            random_float(w);
            v = set_elem(v, i, w);
        end
    endtask

    // inputs move a small delay after the rising edge
    task automatic apply_vectors(input dot_pkg::vec_t a, input dot_pkg::vec_t b);
        @(posedge clk);
        #2;
        a_vec = a;
        b_vec = b;
    endtask

    task automatic wait_done_rise();
        logic prev;
        logic now;

        now = done;
        do begin
            prev = now;
            @(posedge clk);
            #2;
            now = done;
        end while (!(now === 1'b1 && prev !== 1'b1));
    endtask

    task automatic await_result();
        wait_done_rise();
        done_expected++;
        repeat (EXTRA_HOLD) @(posedge clk);
    endtask

    task automatic run_vectors(input dot_pkg::vec_t a, input dot_pkg::vec_t b);
        apply_vectors(a, b);
        await_result();
    endtask

    initial begin
        dot_pkg::vec_t a_next;
        dot_pkg::vec_t b_next;
        fp_pkg::fp32_t w;

        clk           = 1'b0;
        arst_n        = 1'b0;
        seed          = 32'hd736_ec5f;
        cycles        = 0;
        done_expected = 0;
        // reset-time inputs, computed through the pending restart alone
        random_vector(a_next);
        random_vector(b_next);
        a_vec = a_next;
        b_vec = b_next;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        await_result();

        // random pairs, every fourth with one zero element
        for (int t = 0; t < RANDOM_TESTS; t++) begin
            random_vector(a_next);
            random_vector(b_next);
            if (t % 4 == 3) begin
                a_next = set_elem(a_next, t % `DOT_VLEN, '0);
            end
            run_vectors(a_next, b_next);
        end

        // whole zero vectors, then scattered zero elements
        random_vector(b_next);
        run_vectors('0, b_next);
        random_vector(a_next);
        run_vectors(a_next, '0);
        random_vector(a_next);
        random_vector(b_next);
        a_next = set_elem(a_next, 1, '0);
        b_next = set_elem(b_next, `DOT_VLEN - 1, '0);
        run_vectors(a_next, b_next);
        random_vector(a_next);
        random_vector(b_next);
        a_next = set_elem(a_next, 0, '0);
        b_next = set_elem(b_next, 0, '0);
        run_vectors(a_next, b_next);

        // second change lands before the first result is done
        for (int gap = 1; gap <= 3; gap++) begin
            random_vector(a_next);
            random_vector(b_next);
            apply_vectors(a_next, b_next);
            repeat (gap - 1) @(posedge clk);
            random_vector(a_next);
            random_vector(b_next);
            run_vectors(a_next, b_next);
        end

        // first two products cancel exactly, sum restarts from +0
        random_vector(a_next);
        random_vector(b_next);
        a_next = set_elem(a_next, 1, get_elem(a_next, 0));
        w      = get_elem(b_next, 0);
        b_next = set_elem(b_next, 1, {~w[31], w[30:0]});
        run_vectors(a_next, b_next);

        // each odd element cancels the one before it
        random_vector(a_next);
        random_vector(b_next);
        for (int i = 1; i < `DOT_VLEN; i += 2) begin
            a_next = set_elem(a_next, i, get_elem(a_next, i - 1));
            w      = get_elem(b_next, i - 1);
            b_next = set_elem(b_next, i, {~w[31], w[30:0]});
        end
        run_vectors(a_next, b_next);

        // cancelling term arrives after other sums, truncation shows
        random_vector(a_next);
        random_vector(b_next);
        a_next = set_elem(a_next, `DOT_VLEN - 1, get_elem(a_next, 0));
        w      = get_elem(b_next, 0);
        b_next = set_elem(b_next, `DOT_VLEN - 1, {~w[31], w[30:0]});
        run_vectors(a_next, b_next);

        repeat (2) @(posedge clk);
        #2;
        if (checks != done_expected) begin
            $display("expected %0d result checks, the checker made %0d", done_expected, checks);
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0 && checks == done_expected) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/fp_pkg.sv
verilog/dot_pkg.sv
verilog/dot_fetch.sv
verilog/fp_mul_stage.sv
verilog/fp_add.sv
verilog/dot_acc_stage.sv
verilog/dot_product_seq.sv
testbench/dot_checker.sv
testbench/tb_dot_product_seq.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the dot product testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
    --top-module tb_dot_product_seq -Mdir obj_dir -o sim_dot
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_dot)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi
